// File: sim.f
gb_map_pkg.sv
gb_bus_pkg.sv
regbus_if.sv
bus_cycle_fsm.sv
open_bus_timer.sv
work_ram.sv
irq_joypad.sv
gb_sys_top.sv
gb_sys_assert.sv
tb_gb_sys.sv

// File: Bender.yml
package:
  name: gb_sys

sources:
  - files:
      - gb_map_pkg.sv
      - gb_bus_pkg.sv
      - regbus_if.sv
      - bus_cycle_fsm.sv
      - open_bus_timer.sv
      - work_ram.sv
      - irq_joypad.sv
      - gb_sys_top.sv
  - target: simulation
    files:
      - gb_sys_assert.sv
      - tb_gb_sys.sv

// File: tb_gb_sys.sv
`timescale 1ns/1ns
// testbench for the system bus top level
// walks a table of wishbone accesses and pin events through the DUT
// expected bytes follow the memory map, wram banking and interrupt rules

module tb_gb_sys;

	localparam int CLK_PERIOD = 40;
	localparam int DRIVE_DLY  = 2;    // inputs move just after the edge

	typedef enum logic [2:0] {OP_WR, OP_RD, OP_IDLE, OP_IRQ, OP_JOY, OP_ACK, OP_CHK} op_e;

	typedef struct {
		op_e         op;
		logic [15:0] addr;
		logic [7:0]  data;    // write byte, idle cycles or expected irq_o
		logic [7:0]  side;    // cart_oe, irq_req, joy_din or expected p54
		logic [7:0]  exp;     // read byte or expected vector
	} step_t;

	logic        clk_sys, reset_ss;
	logic        wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
	logic [15:0] wb_adr_i;
	logic [7:0]  wb_dat_i, wb_dat_o;
	logic [14:0] cart_addr_o;
	logic        cart_a15_o, cart_rd_o, cart_wr_o, cart_oe_i, ncs_o;
	logic [7:0]  cart_di_o, cart_do_i;
	logic [3:0]  irq_req_i, joy_din_i;
	logic        irq_o, irq_ack_i;
	logic [7:0]  irq_vec_o;
	logic [1:0]  joy_p54_o;

	step_t       steps[$];
	logic [7:0]  fill[8];    // random ram bytes
	integer      seed = 55;
	int          errors = 0;
	int          step_idx = 0;

	gb_sys_top DUT (.*);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	// ----------------------------------------
	// cartridge model whose byte depends on every address bit
	function automatic logic [7:0] cart_byte(input logic [14:0] a);
		return a[7:0] ^ {1'b0, a[14:8]} ^ 8'h96;
	endfunction

	always @(posedge clk_sys) begin
		#DRIVE_DLY;
		if (!$isunknown(cart_addr_o))
			cart_do_i = cart_byte(cart_addr_o);
	end

	function automatic bit cart_region(input logic [15:0] a);
		return (a < 16'hA000 - 16'h2000) || (a >= 16'hA000 && a < 16'hC000);
	endfunction

	// cart ram plus the whole wram range up to the end of echo at fdff
	function automatic bit ncs_region(input logic [15:0] a);
		return (a >= 16'hA000) && (a < 16'hFE00);
	endfunction

	task automatic report_mismatch(input string sig, input logic [15:0] exp_v, act_v);
		errors++;
		$display("mismatch at %0t ns: %s expected %0h got %0h", $time, sig, exp_v, act_v);
	endtask

	task automatic add_step(input op_e op, input logic [15:0] a,
	                        input logic [7:0] d, s, e);
		steps.push_back('{op, a, d, s, e});
	endtask

	// ----------------------------------------
	// wishbone classic master that holds stb until ack
	task automatic bus_access(input bit wr, input logic [15:0] a, input logic [7:0] d,
	                          input logic oe, output logic [7:0] rd);
		int          cycles = 0;
		bit          saw_rd = 1'b0;
		bit          saw_wr = 1'b0;
		bit          saw_cs = 1'b0;
		logic [7:0]  di = 8'h00;
		logic [14:0] ca = 15'h0000;
		logic        a15 = 1'b0;
		wb_cyc_i  = 1'b1;
		wb_stb_i  = 1'b1;
		wb_we_i   = wr;
		wb_adr_i  = a;
		wb_dat_i  = d;
		cart_oe_i = oe;
		do begin
			@(posedge clk_sys);
			#DRIVE_DLY;
			cycles++;
			if (cart_rd_o)
				saw_rd = 1'b1;
			if (cart_wr_o) begin
				saw_wr = 1'b1;
				di     = cart_di_o;
			end
			if (!ncs_o)
				saw_cs = 1'b1;    // chip select seen low
			if (cart_rd_o || cart_wr_o) begin
				a15 = cart_a15_o;
				ca  = cart_addr_o;
			end
		end while (!wb_ack_o);
		rd = wb_dat_o;    // valid while ack
		@(posedge clk_sys);
		#DRIVE_DLY;
		wb_stb_i = 1'b0;    // ack sampled on that edge
		wb_cyc_i = 1'b0;
		wb_we_i  = 1'b0;
		if (cycles != 2)
			report_mismatch("wb_ack_o latency", 2, cycles);
		if (wb_ack_o !== 1'b0)
			report_mismatch("wb_ack_o width", 0, wb_ack_o);
		if (saw_rd != (cart_region(a) && !wr))
			report_mismatch("cart_rd_o", !saw_rd, saw_rd);
		if (saw_wr != (cart_region(a) && wr))
			report_mismatch("cart_wr_o", !saw_wr, saw_wr);
		if (saw_cs != ncs_region(a))
			report_mismatch("ncs_o low", ncs_region(a), saw_cs);
		if (cart_region(a) && a15 !== a[15])
			report_mismatch("cart_a15_o", a[15], a15);
		if (cart_region(a) && ca !== a[14:0])
			report_mismatch("cart_addr_o", a[14:0], ca);
		if (cart_region(a) && wr && di !== d)
			report_mismatch("cart_di_o", d, di);
	endtask

	// ----------------------------------------
	// stimulus table
	task automatic build_table();
		// low three bits carry the index so no two fill bytes match
		foreach (fill[i])
			fill[i] = {5'($random(seed)), 3'(i)};
		// reset state, bank register and decayed open bus
		add_step(OP_RD,  16'hFF70, 8'h00, 8'h00, 8'hF8);
		add_step(OP_RD,  16'h4000, 8'h00, 8'h00, 8'hFF);
		add_step(OP_CHK, 16'h0000, 8'h00, 8'h00, 8'h00);
		// wram banks 2 and 3 at d000
		add_step(OP_WR,  16'hFF70, 8'h02, 8'h00, 8'h00);
		add_step(OP_WR,  16'hD000, fill[0], 8'h00, 8'h00);
		add_step(OP_WR,  16'hFF70, 8'h03, 8'h00, 8'h00);
		add_step(OP_WR,  16'hD000, fill[1], 8'h00, 8'h00);
		add_step(OP_RD,  16'hD000, 8'h00, 8'h00, fill[1]);
		add_step(OP_WR,  16'hFF70, 8'h02, 8'h00, 8'h00);
		add_step(OP_RD,  16'hD000, 8'h00, 8'h00, fill[0]);
		add_step(OP_WR,  16'hFF70, 8'h00, 8'h00, 8'h00);    // 0 aliases bank 1
		add_step(OP_WR,  16'hD000, fill[2], 8'h00, 8'h00);
		add_step(OP_WR,  16'hFF70, 8'h01, 8'h00, 8'h00);
		add_step(OP_RD,  16'hD000, 8'h00, 8'h00, fill[2]);
		add_step(OP_RD,  16'hFF70, 8'h00, 8'h00, 8'hF9);
		// c000 fixed and the echo region
		add_step(OP_WR,  16'hC000, fill[3], 8'h00, 8'h00);
		add_step(OP_WR,  16'hFF70, 8'h03, 8'h00, 8'h00);
		add_step(OP_RD,  16'hC000, 8'h00, 8'h00, fill[3]);
		add_step(OP_RD,  16'hE000, 8'h00, 8'h00, fill[3]);
		add_step(OP_WR,  16'hFDFF, fill[4], 8'h00, 8'h00);    // lands on ddff in bank 3
		add_step(OP_RD,  16'hDDFF, 8'h00, 8'h00, fill[4]);
		// high ram, ie and a hole in the register page
		add_step(OP_WR,  16'hFF80, fill[5], 8'h00, 8'h00);
		add_step(OP_WR,  16'hFFFE, fill[6], 8'h00, 8'h00);
		add_step(OP_RD,  16'hFF80, 8'h00, 8'h00, fill[5]);
		add_step(OP_WR,  16'hFFFF, fill[7], 8'h00, 8'h00);
		add_step(OP_RD,  16'hFFFE, 8'h00, 8'h00, fill[6]);
		add_step(OP_RD,  16'hFFFF, 8'h00, 8'h00, fill[7]);
		add_step(OP_RD,  16'hFF03, 8'h00, 8'h00, 8'hFF);
		// interrupts
		add_step(OP_WR,  16'hFFFF, 8'h00, 8'h00, 8'h00);
		add_step(OP_IRQ, 16'h0000, 8'h00, 8'h05, 8'h00);    // vblank and timer rise
		add_step(OP_CHK, 16'h0000, 8'h00, 8'h00, 8'h00);
		add_step(OP_RD,  16'hFF0F, 8'h00, 8'h00, 8'hE5);
		add_step(OP_WR,  16'hFFFF, 8'h04, 8'h00, 8'h00);
		add_step(OP_CHK, 16'h0000, 8'h01, 8'h00, 8'h50);
		add_step(OP_WR,  16'hFFFF, 8'h05, 8'h00, 8'h00);
		add_step(OP_CHK, 16'h0000, 8'h01, 8'h00, 8'h40);
		add_step(OP_ACK, 16'h0000, 8'h00, 8'h00, 8'h00);
		add_step(OP_CHK, 16'h0000, 8'h01, 8'h00, 8'h50);
		add_step(OP_RD,  16'hFF0F, 8'h00, 8'h00, 8'hE4);
		add_step(OP_ACK, 16'h0000, 8'h00, 8'h00, 8'h00);
		add_step(OP_CHK, 16'h0000, 8'h00, 8'h00, 8'h00);
		add_step(OP_IRQ, 16'h0000, 8'h00, 8'h0F, 8'h00);    // lcd and serial stay masked
		add_step(OP_ACK, 16'h0000, 8'h00, 8'h00, 8'h00);    // nothing to clear
		add_step(OP_RD,  16'hFF0F, 8'h00, 8'h00, 8'hEA);
		// joypad select and the joypad flag
		add_step(OP_WR,  16'hFF00, 8'h10, 8'h00, 8'h00);
		add_step(OP_CHK, 16'h0000, 8'h00, 8'h01, 8'h00);
		add_step(OP_RD,  16'hFF00, 8'h00, 8'h00, 8'hDF);
		add_step(OP_JOY, 16'h0000, 8'h00, 8'h0E, 8'h00);
		add_step(OP_RD,  16'hFF0F, 8'h00, 8'h00, 8'hFA);
		add_step(OP_RD,  16'hFF00, 8'h00, 8'h00, 8'hDE);
		add_step(OP_WR,  16'hFFFF, 8'h10, 8'h00, 8'h00);
		add_step(OP_CHK, 16'h0000, 8'h01, 8'h01, 8'h60);
		add_step(OP_JOY, 16'h0000, 8'h00, 8'h0F, 8'h00);
		// cartridge reads, open bus hold and decay, writes
		add_step(OP_RD,  16'h1234, 8'h00, 8'h01, cart_byte(15'h1234));
		add_step(OP_RD,  16'hA010, 8'h00, 8'h01, cart_byte(15'h2010));
		add_step(OP_RD,  16'hA020, 8'h00, 8'h00, cart_byte(15'h2010));    // cart silent
		add_step(OP_IDLE, 16'h0000, 8'd8, 8'h00, 8'h00);
		add_step(OP_RD,  16'hA020, 8'h00, 8'h00, 8'hFF);
		add_step(OP_WR,  16'hA030, 8'h3C, 8'h00, 8'h00);
		add_step(OP_WR,  16'h2000, 8'h05, 8'h00, 8'h00);    // mbc style write to the rom area
	endtask

	// ----------------------------------------
	initial begin
		logic [7:0] rd_byte;
		reset_ss  = 1'b1;
		wb_cyc_i  = 1'b0;
		wb_stb_i  = 1'b0;
		wb_we_i   = 1'b0;
		wb_adr_i  = 16'h0000;
		wb_dat_i  = 8'h00;
		cart_do_i = 8'h00;
		cart_oe_i = 1'b0;
		irq_req_i = 4'h0;
		irq_ack_i = 1'b0;
		joy_din_i = 4'hF;    // buttons released
		build_table();
		repeat (2) @(posedge clk_sys);
		#DRIVE_DLY;
		reset_ss = 1'b0;
		if (wb_ack_o !== 1'b0) report_mismatch("wb_ack_o", 0, wb_ack_o);
		if (irq_o !== 1'b0) report_mismatch("irq_o", 0, irq_o);
		if (cart_rd_o !== 1'b0) report_mismatch("cart_rd_o", 0, cart_rd_o);
		if (cart_wr_o !== 1'b0) report_mismatch("cart_wr_o", 0, cart_wr_o);
		if (ncs_o !== 1'b1) report_mismatch("ncs_o", 1, ncs_o);

		for (int i = 0; i < steps.size(); i++) begin
			step_idx = i;
			case (steps[i].op)
				OP_WR: begin
					bus_access(1'b1, steps[i].addr, steps[i].data, steps[i].side[0],
					           rd_byte);
				end
				OP_RD: begin
					bus_access(1'b0, steps[i].addr, 8'h00, steps[i].side[0], rd_byte);
					if (rd_byte !== steps[i].exp)
						report_mismatch($sformatf("wb_dat_o[%h]", steps[i].addr),
						                steps[i].exp, rd_byte);
				end
				OP_IDLE: begin
					repeat (steps[i].data) @(posedge clk_sys);
					#DRIVE_DLY;
				end
				OP_IRQ: begin
					irq_req_i = steps[i].side[3:0];
					@(posedge clk_sys);
					#DRIVE_DLY;
				end
				OP_JOY: begin
					joy_din_i = steps[i].side[3:0];
					repeat (2) @(posedge clk_sys);    // two sync stages
					#DRIVE_DLY;
				end
				OP_ACK: begin
					irq_ack_i = 1'b1;
					@(posedge clk_sys);
					#DRIVE_DLY;
					irq_ack_i = 1'b0;    // falling edge clears
					@(posedge clk_sys);
					#DRIVE_DLY;
				end
				default: begin
					if (irq_o !== steps[i].data[0])
						report_mismatch("irq_o", steps[i].data[0], irq_o);
					if (irq_vec_o !== steps[i].exp)
						report_mismatch("irq_vec_o", steps[i].exp, irq_vec_o);
					if (joy_p54_o !== steps[i].side[1:0])
						report_mismatch("joy_p54_o", steps[i].side[1:0], joy_p54_o);
				end
			endcase
		end

		$display("summary: %0d check errors, %0d assertion failures",
		         errors, DUT.u_assert.assert_fails);
		if (errors == 0 && DUT.u_assert.assert_fails == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	// watchdog sized from the table
	initial begin
		#1;
		#(steps.size() * 20 * CLK_PERIOD + 2000);
		$display("timeout: stuck at step %0d of %0d, %0d errors so far",
		         step_idx, steps.size(), errors);
		$display("Errors found");
		$finish;
	end

endmodule

// File: gb_sys_assert.sv
`timescale 1ns/1ns
// concurrent checks on wishbone timing, cart strobes and the irq line
// attached to gb_sys_top by the bind at the end of this file

module gb_sys_assert (
	input logic                          clk_sys,
	input logic                          reset_ss,
	input logic                          wb_cyc_i,
	input logic                          wb_stb_i,
	input logic                          wb_ack_o,
	input logic                          cart_rd_o,
	input logic                          cart_wr_o,
	input logic                          irq_o,
	input logic [gb_bus_pkg::DATA_W-1:0] ie_i,
	input logic [gb_bus_pkg::IRQ_N-1:0]  if_i
);

	int   assert_fails = 0;    // failure tally
	logic req_wait;            // request still waiting for its ack

	assign req_wait = wb_cyc_i && wb_stb_i && !wb_ack_o;

	// single cycle ack
	ack_one_cycle: assert property (@(posedge clk_sys) disable iff (reset_ss)
		wb_ack_o |=> !wb_ack_o)
		else begin
			$error("wb_ack_o stayed high for more than one cycle");
			assert_fails++;
		end

	// ack two cycles after a new request, back to back ones included
	ack_latency: assert property (@(posedge clk_sys) disable iff (reset_ss)
		$rose(req_wait) |=> !wb_ack_o ##1 wb_ack_o)
		else begin
			$error("wb_ack_o did not follow stb by two cycles");
			assert_fails++;
		end

	cart_strobes: assert property (@(posedge clk_sys) disable iff (reset_ss)
		!(cart_rd_o && cart_wr_o))
		else begin
			$error("cart_rd_o and cart_wr_o high together");
			assert_fails++;
		end

	// irq only with an enabled pending flag
	irq_needs_pending: assert property (@(posedge clk_sys) disable iff (reset_ss)
		irq_o |-> |(ie_i[gb_bus_pkg::IRQ_N-1:0] & if_i))
		else begin
			$error("irq_o high without an enabled pending flag");
			assert_fails++;
		end

endmodule

bind gb_sys_top gb_sys_assert u_assert (
	.clk_sys   (clk_sys),
	.reset_ss  (reset_ss),
	.wb_cyc_i  (wb_cyc_i),
	.wb_stb_i  (wb_stb_i),
	.wb_ack_o  (wb_ack_o),
	.cart_rd_o (cart_rd_o),
	.cart_wr_o (cart_wr_o),
	.irq_o     (irq_o),
	.ie_i      (u_irq.ie_r),
	.if_i      (u_irq.if_r)
);

// File: gb_sys_top.sv
`timescale 1ns/1ns
// system bus top level
// wishbone slave in front, cartridge bus, interrupt and joypad pins out

module gb_sys_top (
	input  logic                            clk_sys,
	input  logic                            reset_ss,
	// wishbone slave
	input  logic                            wb_cyc_i,
	input  logic                            wb_stb_i,
	input  logic                            wb_we_i,
	input  logic [gb_bus_pkg::ADDR_W-1:0]   wb_adr_i,
	input  logic [gb_bus_pkg::DATA_W-1:0]   wb_dat_i,
	output logic [gb_bus_pkg::DATA_W-1:0]   wb_dat_o,
	output logic                            wb_ack_o,
	// cartridge
	output logic [gb_bus_pkg::ADDR_W-2:0]   cart_addr_o,
	output logic                            cart_a15_o,
	output logic                            cart_rd_o,
	output logic                            cart_wr_o,
	output logic [gb_bus_pkg::DATA_W-1:0]   cart_di_o,
	input  logic [gb_bus_pkg::DATA_W-1:0]   cart_do_i,
	input  logic                            cart_oe_i,
	output logic                            ncs_o,
	// interrupts
	input  logic [gb_bus_pkg::IRQ_N-2:0]    irq_req_i,    // vblank lcd timer serial
	output logic                            irq_o,
	output logic [gb_bus_pkg::DATA_W-1:0]   irq_vec_o,
	input  logic                            irq_ack_i,
	// joypad
	input  logic [3:0]                      joy_din_i,
	output logic [1:0]                      joy_p54_o
);

	logic                          cart_access;
	logic [gb_bus_pkg::DATA_W-1:0] cart_rdata;

	regbus_if #(.AW(gb_bus_pkg::ADDR_W), .DW(gb_bus_pkg::DATA_W)) ram_bus ();
	regbus_if #(.AW(gb_bus_pkg::ADDR_W), .DW(gb_bus_pkg::DATA_W)) reg_bus ();

	// ----------------------------------------
	bus_cycle_fsm u_fsm (
		.clk_sys       (clk_sys),
		.reset_ss      (reset_ss),
		.wb_cyc_i      (wb_cyc_i),
		.wb_stb_i      (wb_stb_i),
		.wb_we_i       (wb_we_i),
		.wb_adr_i      (wb_adr_i),
		.wb_dat_i      (wb_dat_i),
		.wb_dat_o      (wb_dat_o),
		.wb_ack_o      (wb_ack_o),
		.cart_addr_o   (cart_addr_o),
		.cart_a15_o    (cart_a15_o),
		.cart_rd_o     (cart_rd_o),
		.cart_wr_o     (cart_wr_o),
		.cart_di_o     (cart_di_o),
		.cart_do_i     (cart_do_i),
		.cart_oe_i     (cart_oe_i),
		.ncs_o         (ncs_o),
		.cart_access_o (cart_access),
		.cart_rdata_i  (cart_rdata),
		.ram_bus       (ram_bus),
		.reg_bus       (reg_bus)
	);

	open_bus_timer u_open_bus (
		.clk_sys       (clk_sys),
		.reset_ss      (reset_ss),
		.cart_access_i (cart_access),
		.cart_oe_i     (cart_oe_i),
		.cart_do_i     (cart_do_i),
		.cart_rdata_o  (cart_rdata)
	);

	work_ram u_wram (
		.clk_sys  (clk_sys),
		.reset_ss (reset_ss),
		.bus      (ram_bus)
	);

	irq_joypad u_irq (
		.clk_sys   (clk_sys),
		.reset_ss  (reset_ss),
		.irq_req_i (irq_req_i),
		.irq_ack_i (irq_ack_i),
		.joy_din_i (joy_din_i),
		.irq_o     (irq_o),
		.irq_vec_o (irq_vec_o),
		.joy_p54_o (joy_p54_o),
		.bus       (reg_bus)
	);

endmodule

// File: irq_joypad.sv
`timescale 1ns/1ns
// interrupt controller (IE, IF, vector, ack) and the joypad select register
// request edges set flags, irq_ack_i falling clears the winning flag

module irq_joypad (
	input  logic                             clk_sys,
	input  logic                             reset_ss,
	input  logic [gb_bus_pkg::IRQ_N-2:0]     irq_req_i,    // joypad source is local
	input  logic                             irq_ack_i,
	input  logic [3:0]                       joy_din_i,
	output logic                             irq_o,
	output logic [gb_bus_pkg::DATA_W-1:0]    irq_vec_o,
	output logic [1:0]                       joy_p54_o,
	regbus_if.target                         bus
);

	logic [gb_bus_pkg::DATA_W-1:0] ie_r;
	logic [gb_bus_pkg::IRQ_N-1:0]  if_r;
	logic [gb_bus_pkg::IRQ_N-2:0]  req_d;       // previous request levels
	logic [3:0]                    joy_s1, joy_s2;
	logic                          ack_d;
	logic [1:0]                    p54;

	logic [gb_bus_pkg::IRQ_N-2:0]  req_rise;
	logic [3:0]                    joy_fall;
	logic                          ack_fall;
	logic [gb_bus_pkg::IRQ_N-1:0]  pending;
	logic [gb_bus_pkg::IRQ_N-1:0]  if_set, clr_mask;
	logic [2:0]                    pend_idx;
	logic                          pend_any;
	logic                          ie_hit, if_hit;

	// ----------------------------------------
	// edge detect
	assign req_rise = irq_req_i & ~req_d;
	assign joy_fall = joy_s2 & ~joy_s1;    // any P10..P13 going low
	assign ack_fall = ack_d & ~irq_ack_i;
	assign if_set   = {|joy_fall, req_rise};

	// ----------------------------------------
	// priority, lowest index wins
	assign pending  = ie_r[gb_bus_pkg::IRQ_N-1:0] & if_r;
	assign pend_any = |pending;
	assign clr_mask = ack_fall ? (pending & (~pending + 1'b1)) : '0;    // lowest set bit

	always_comb begin
		pend_idx = '0;
		for (int i = gb_bus_pkg::IRQ_N - 1; i >= 0; i--) begin
			if (pending[i])
				pend_idx = 3'(i);
		end
	end

	assign irq_o     = pend_any;
	assign irq_vec_o = pend_any ?
	                   gb_bus_pkg::IRQ_VEC_BASE + gb_bus_pkg::IRQ_VEC_STEP * pend_idx : '0;

	// register select, sequencer only sends ff00 ff0f ffff here
	assign ie_hit = bus.addr[7];
	assign if_hit = !bus.addr[7] && bus.addr[3];

	// ----------------------------------------
	// control registers
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			ie_r   <= '0;
			if_r   <= '0;
			req_d  <= '0;
			joy_s1 <= '1;    // lines idle high
			joy_s2 <= '1;
			ack_d  <= 1'b0;
			p54    <= '0;
		end else begin
			req_d  <= irq_req_i;
			joy_s1 <= joy_din_i;
			joy_s2 <= joy_s1;
			ack_d  <= irq_ack_i;

			if_r <= (if_r | if_set) & ~clr_mask;

			// bus writes win over events in the same cycle
			if (bus.sel && bus.we) begin
				if (ie_hit)
					ie_r <= bus.wdata;
				else if (if_hit)
					if_r <= bus.wdata[gb_bus_pkg::IRQ_N-1:0];
				else
					p54 <= bus.wdata[5:4];    // joyp select
			end
		end
	end

	// read register
	always_ff @(posedge clk_sys) begin
		if (bus.sel) begin
			if (ie_hit)
				bus.rdata <= ie_r;
			else if (if_hit)
				bus.rdata <= {{(gb_bus_pkg::DATA_W - gb_bus_pkg::IRQ_N){1'b1}}, if_r};
			else
				bus.rdata <= {2'b11, p54, joy_din_i};
		end
	end

	assign joy_p54_o = p54;

endmodule

// File: work_ram.sv
`timescale 1ns/1ns
// banked work ram, high ram and the svbk register
// sits behind the sequencer ram port, echo addresses arrive already folded

module work_ram (
	input  logic       clk_sys,
	input  logic       reset_ss,
	regbus_if.target   bus
);

	logic [gb_bus_pkg::DATA_W-1:0] wram [0:(1 << gb_map_pkg::WRAM_ADDR_W)-1];
	logic [gb_bus_pkg::DATA_W-1:0] hram [0:(1 << gb_map_pkg::HRAM_ADDR_W)-2];    // ffff is IE

	logic [gb_map_pkg::WRAM_BANK_W-1:0] bank;
	logic [gb_map_pkg::WRAM_BANK_W-1:0] bank_eff;
	logic [gb_map_pkg::WRAM_ADDR_W-1:0] wram_addr;
	logic [gb_map_pkg::HRAM_ADDR_W-1:0] hram_addr;
	logic                               wram_hit, hram_hit, svbk_hit;

	// ----------------------------------------
	// local decode
	// bit 13 is clear only for folded c000-dfff
	assign wram_hit = !bus.addr[13];
	assign hram_hit = bus.addr[13] && bus.addr[7];     // ff80 and up
	assign svbk_hit = bus.addr[13] && !bus.addr[7];    // ff70

	// bank 0 in svbk still maps bank 1 at d000
	assign bank_eff  = (bank == '0) ? gb_map_pkg::WRAM_BANK_W'(1) : bank;
	assign wram_addr = bus.addr[12] ?
	                   {bank_eff, bus.addr[11:0]} :                         // d000 banked
	                   {{gb_map_pkg::WRAM_BANK_W{1'b0}}, bus.addr[11:0]};   // c000 fixed
	assign hram_addr = bus.addr[gb_map_pkg::HRAM_ADDR_W-1:0];

	// ----------------------------------------
	// svbk
	always_ff @(posedge clk_sys) begin
		if (reset_ss)
			bank <= '0;
		else if (bus.sel && bus.we && svbk_hit)
			bank <= bus.wdata[gb_map_pkg::WRAM_BANK_W-1:0];
	end

	// ----------------------------------------
	// ram arrays and read register
	always_ff @(posedge clk_sys) begin
		if (bus.sel) begin
			if (bus.we && wram_hit)
				wram[wram_addr] <= bus.wdata;
			if (bus.we && hram_hit)
				hram[hram_addr] <= bus.wdata;

			// read before write, held until the next sel
			if (wram_hit)
				bus.rdata <= wram[wram_addr];
			else if (hram_hit)
				bus.rdata <= hram[hram_addr];
			else
				bus.rdata <= {{(gb_bus_pkg::DATA_W - gb_map_pkg::WRAM_BANK_W){1'b1}}, bank};
		end
	end

endmodule

// File: open_bus_timer.sv
`timescale 1ns/1ns
// cartridge open bus model
// keeps the last byte the cart really drove, which a read with oe low
// returns until the pull-ups win after a few cycles

module open_bus_timer (
	input  logic                            clk_sys,
	input  logic                            reset_ss,
	input  logic                            cart_access_i,    // one cycle per cart read
	input  logic                            cart_oe_i,
	input  logic [gb_bus_pkg::DATA_W-1:0]   cart_do_i,
	output logic [gb_bus_pkg::DATA_W-1:0]   cart_rdata_o
);

	logic [gb_bus_pkg::DATA_W-1:0]         held;
	logic [gb_bus_pkg::OPEN_BUS_CNT_W-1:0] cnt;
	logic [gb_bus_pkg::OPEN_BUS_CNT_W-1:0] cnt_next;

	assign cnt_next = cnt + 1'b1;

	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			held <= gb_bus_pkg::OPEN_BYTE;    // starts already decayed
			cnt  <= '1;
		end else if (cart_access_i && cart_oe_i) begin
			held <= cart_do_i;    // fresh byte from the cart
			cnt  <= '0;
		end else if (!(&cnt)) begin
			cnt <= cnt_next;    // saturates
			if (cnt_next == gb_bus_pkg::OPEN_BUS_DECAY)
				held <= gb_bus_pkg::OPEN_BYTE;    // slow pull-up
		end
	end

	assign cart_rdata_o = held;

endmodule

// File: bus_cycle_fsm.sv
`timescale 1ns/1ns
// wishbone classic slave sequencer for the system bus
// latches a request, decodes it, gives the owning target or the cartridge
// one access cycle and acks with the steered read byte two cycles later

module bus_cycle_fsm (
	input  logic                            clk_sys,
	input  logic                            reset_ss,
	// wishbone slave
	input  logic                            wb_cyc_i,
	input  logic                            wb_stb_i,
	input  logic                            wb_we_i,
	input  logic [gb_bus_pkg::ADDR_W-1:0]   wb_adr_i,
	input  logic [gb_bus_pkg::DATA_W-1:0]   wb_dat_i,
	output logic [gb_bus_pkg::DATA_W-1:0]   wb_dat_o,
	output logic                            wb_ack_o,
	// cartridge bus
	output logic [gb_bus_pkg::ADDR_W-2:0]   cart_addr_o,    // a15 split off
	output logic                            cart_a15_o,
	output logic                            cart_rd_o,
	output logic                            cart_wr_o,
	output logic [gb_bus_pkg::DATA_W-1:0]   cart_di_o,
	input  logic [gb_bus_pkg::DATA_W-1:0]   cart_do_i,
	input  logic                            cart_oe_i,
	output logic                            ncs_o,
	// open bus timer
	output logic                            cart_access_o,
	input  logic [gb_bus_pkg::DATA_W-1:0]   cart_rdata_i,
	// internal targets
	regbus_if.host                          ram_bus,
	regbus_if.host                          reg_bus
);

	gb_bus_pkg::fsm_state_e state;
	gb_map_pkg::region_e    region;      // decode of the latched address
	gb_map_pkg::region_e    region_q;    // held for read steering in ACK

	logic [gb_bus_pkg::ADDR_W-1:0] adr_q;
	logic [gb_bus_pkg::DATA_W-1:0] dat_q;
	logic [gb_bus_pkg::DATA_W-1:0] cart_byte_q;
	logic                          we_q;
	logic                          in_access;
	logic                          is_cart, is_ram, is_reg, ext_cs;

	// ----------------------------------------
	// bus cycle FSM
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			state <= gb_bus_pkg::ST_IDLE;
		end else begin
			case (state)
				gb_bus_pkg::ST_IDLE:   if (wb_cyc_i && wb_stb_i) state <= gb_bus_pkg::ST_ACCESS;
				gb_bus_pkg::ST_ACCESS: state <= gb_bus_pkg::ST_ACK;    // never stalls
				default:               state <= gb_bus_pkg::ST_IDLE;
			endcase
		end
	end

	assign in_access = (state == gb_bus_pkg::ST_ACCESS);
	assign wb_ack_o  = (state == gb_bus_pkg::ST_ACK);

	// request capture, and the cart byte at the end of ACCESS
	always_ff @(posedge clk_sys) begin
		if (state == gb_bus_pkg::ST_IDLE && wb_cyc_i && wb_stb_i) begin
			adr_q <= wb_adr_i;
			dat_q <= wb_dat_i;
			we_q  <= wb_we_i;
		end
		if (in_access) begin
			region_q    <= region;
			cart_byte_q <= cart_oe_i ? cart_do_i : cart_rdata_i;    // cart drove it or open bus
		end
	end

	// ----------------------------------------
	// address decode
	always_comb begin
		region = gb_map_pkg::RGN_UNMAPPED;
		if (!adr_q[15])
			region = gb_map_pkg::RGN_CART_ROM;
		else if (adr_q[15:13] == gb_map_pkg::CRAM_BASE[15:13])
			region = gb_map_pkg::RGN_CART_RAM;
		else if (adr_q[15:13] == gb_map_pkg::WRAM_BASE[15:13])
			region = gb_map_pkg::RGN_WRAM;
		else if (adr_q[15:13] == gb_map_pkg::WRAM_MIRROR_BASE[15:13] && !(&adr_q[12:9]))
			region = gb_map_pkg::RGN_WRAM_MIRROR;    // stops below fe00
		else if (adr_q == gb_map_pkg::ADDR_IE)
			region = gb_map_pkg::RGN_IE;             // ahead of hram, ffff is not ram
		else if (adr_q[15:7] == gb_map_pkg::HRAM_BASE[15:7])
			region = gb_map_pkg::RGN_HRAM;
		else if (adr_q == gb_map_pkg::ADDR_IF)
			region = gb_map_pkg::RGN_IF;
		else if (adr_q == gb_map_pkg::ADDR_JOYP)
			region = gb_map_pkg::RGN_JOYP;
		else if (adr_q == gb_map_pkg::ADDR_SVBK)
			region = gb_map_pkg::RGN_SVBK;
	end

	assign is_cart = (region == gb_map_pkg::RGN_CART_ROM) || (region == gb_map_pkg::RGN_CART_RAM);
	assign is_ram  = (region == gb_map_pkg::RGN_WRAM) || (region == gb_map_pkg::RGN_WRAM_MIRROR) ||
	                 (region == gb_map_pkg::RGN_HRAM) || (region == gb_map_pkg::RGN_SVBK);
	assign is_reg  = (region == gb_map_pkg::RGN_IE) || (region == gb_map_pkg::RGN_IF) ||
	                 (region == gb_map_pkg::RGN_JOYP);
	// chip select covers cart ram and the whole wram range
	assign ext_cs  = (region == gb_map_pkg::RGN_CART_RAM) || (region == gb_map_pkg::RGN_WRAM) ||
	                 (region == gb_map_pkg::RGN_WRAM_MIRROR);

	// ----------------------------------------
	// cartridge side
	assign cart_addr_o   = adr_q[14:0];
	assign cart_a15_o    = adr_q[15];
	assign cart_di_o     = dat_q;
	assign cart_rd_o     = in_access && is_cart && !we_q;
	assign cart_wr_o     = in_access && is_cart && we_q;
	assign cart_access_o = cart_rd_o;    // timer only tracks reads
	assign ncs_o         = !((state != gb_bus_pkg::ST_IDLE) && ext_cs);    // low for the whole cycle

	// ----------------------------------------
	// internal targets
	assign ram_bus.sel   = in_access && is_ram;
	assign ram_bus.we    = we_q;
	assign ram_bus.wdata = dat_q;
	// echo folded onto c000, bit 13 then splits wram from ff70/ff80
	assign ram_bus.addr  = (region == gb_map_pkg::RGN_WRAM_MIRROR) ?
	                       {gb_map_pkg::WRAM_BASE[15:13], adr_q[12:0]} : adr_q;

	assign reg_bus.sel   = in_access && is_reg;
	assign reg_bus.we    = we_q;
	assign reg_bus.wdata = dat_q;
	assign reg_bus.addr  = adr_q;

	// read steering, valid while ack is high
	always_comb begin
		case (region_q)
			gb_map_pkg::RGN_CART_ROM,
			gb_map_pkg::RGN_CART_RAM:    wb_dat_o = cart_byte_q;
			gb_map_pkg::RGN_WRAM,
			gb_map_pkg::RGN_WRAM_MIRROR,
			gb_map_pkg::RGN_HRAM,
			gb_map_pkg::RGN_SVBK:        wb_dat_o = ram_bus.rdata;
			gb_map_pkg::RGN_IE,
			gb_map_pkg::RGN_IF,
			gb_map_pkg::RGN_JOYP:        wb_dat_o = reg_bus.rdata;
			default:                     wb_dat_o = gb_bus_pkg::OPEN_BYTE;
		endcase
	end

endmodule

// File: regbus_if.sv
`timescale 1ns/1ns
// one byte access from the bus sequencer to a RAM or register block
// sel pulses for one clock, a write lands on that edge
// rdata is registered on the same edge and held until the next sel

interface regbus_if #(
	parameter int AW = 16,
	parameter int DW = 8
);
	logic          sel;
	logic          we;
	logic [AW-1:0] addr;
	logic [DW-1:0] wdata;
	logic [DW-1:0] rdata;

	modport host (
		output sel, we, addr, wdata,
		input  rdata
	);

	modport target (
		input  sel, we, addr, wdata,
		output rdata
	);
endinterface

// File: gb_bus_pkg.sv
// bus widths, sequencer states and interrupt / open bus constants
// used by every block that sits on the system bus

package gb_bus_pkg;

	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;

	// floating bus reads back high
	localparam logic [7:0] OPEN_BYTE = 8'hFF;

	// wishbone bus cycle sequencer
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ACCESS,    // one cycle, target sees sel
		ST_ACK
	} fsm_state_e;

	// ----------------------------------------
	// interrupts
	localparam int IRQ_N = 5;    // vblank lcd timer serial joypad

	// vector = base + step * source index
	localparam logic [7:0] IRQ_VEC_BASE = 8'h40;
	localparam logic [7:0] IRQ_VEC_STEP = 8'h08;

	// ----------------------------------------
	// open bus pull-up
	localparam int OPEN_BUS_DECAY = 4;    // cycles until the byte is lost
	localparam int OPEN_BUS_CNT_W = 3;

endpackage

// File: gb_map_pkg.sv
// address map of the system bus
// region codes shared by the sequencer decode and the targets behind it

package gb_map_pkg;

	// decoded bus targets
	typedef enum logic [3:0] {
		RGN_CART_ROM,       // 0000-7fff on the cartridge
		RGN_CART_RAM,       // a000-bfff on the cartridge
		RGN_WRAM,           // c000-dfff
		RGN_WRAM_MIRROR,    // e000-fdff echo of c000
		RGN_HRAM,           // ff80-fffe
		RGN_IE,
		RGN_IF,
		RGN_JOYP,
		RGN_SVBK,
		RGN_UNMAPPED        // reads back as open bus
	} region_e;

	// ----------------------------------------
	// region bases
	localparam logic [15:0] CRAM_BASE        = 16'hA000;
	localparam logic [15:0] WRAM_BASE        = 16'hC000;
	localparam logic [15:0] WRAM_MIRROR_BASE = 16'hE000;
	localparam logic [15:0] HRAM_BASE        = 16'hFF80;

	// ----------------------------------------
	// single registers
	localparam logic [15:0] ADDR_JOYP = 16'hFF00;
	localparam logic [15:0] ADDR_IF   = 16'hFF0F;
	localparam logic [15:0] ADDR_SVBK = 16'hFF70;
	localparam logic [15:0] ADDR_IE   = 16'hFFFF;

	localparam int WRAM_BANK_W = 3;    // svbk bits
	localparam int WRAM_ADDR_W = 15;   // 8 banks of 4k
	localparam int HRAM_ADDR_W = 7;

endpackage
